//--- files.f
source/phy_lane_pkg.sv
source/phy_code_pkg.sv
source/phy_tx_mux.sv
source/phy_serializer.sv
source/phy_tx.sv
source/phy_deserializer.sv
source/phy_rx.sv
source/phy.sv
verif/phy_tb.sv

//--- Bender.yml
package:
  name: phy

sources:
  - source/phy_lane_pkg.sv
  - source/phy_code_pkg.sv
  - source/phy_tx_mux.sv
  - source/phy_serializer.sv
  - source/phy_tx.sv
  - source/phy_deserializer.sv
  - source/phy_rx.sv
  - source/phy.sv
  - target: test
    files:
      - verif/phy_tb.sv

//--- verif/phy_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY testbench, recirculation, lock and
// loopback checks from a stimulus table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_tb;

  localparam int num_rows     = 24;
  localparam int clk_period   = 40;
  localparam int frame_cycles = 32;
  localparam int reset_cycles = 16;
  localparam int lock_limit   = 6 * frame_cycles;
  localparam int lock_margin  = 400;
  localparam int run_cycles   = num_rows * frame_cycles + lock_margin + 2 * reset_cycles;

  logic                      clk32f = 1'b0;
  logic                      reset;
  phy_lane_pkg::lane_bus_t   lanes_in;
  phy_lane_pkg::lane_bus_t   lanes_out;
  logic                      out_strobe;
  phy_lane_pkg::lane_bus_t   lanes_recir;
  logic                      in_taken;
  logic                      active;

  phy_lane_pkg::lane_bus_t   stim [num_rows];
  phy_lane_pkg::lane_bus_t   exp_out [num_rows];
  phy_lane_pkg::lane_bus_t   exp_q [$];
  phy_lane_pkg::lane_bus_t   recir_exp;
  phy_lane_pkg::lane_valid_t recir_mask;
  logic                      recir_pending;
  logic                      seen_active;
  int                        rel_cycle;
  int                        row_idx;
  int                        row_limit;
  int                        loop_count;
  int                        low_rows;
  int unsigned               seed_val;

  phy #(
    .bits_per_byte (8)
  ) i_phy (
    .clk32f      (clk32f),
    .reset       (reset),
    .lanes_in    (lanes_in),
    .lanes_out   (lanes_out),
    .out_strobe  (out_strobe),
    .lanes_recir (lanes_recir),
    .in_taken    (in_taken),
    .active      (active)
  );

  initial begin
    forever #(clk_period / 2) clk32f = ~clk32f;
  end

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  function automatic phy_lane_pkg::lane_byte_t lane_byte(input phy_lane_pkg::lane_bus_t bus,
                                                         input int idx);
    case (idx)
      0:       return bus.lane0;
      1:       return bus.lane1;
      2:       return bus.lane2;
      default: return bus.lane3;
    endcase
  endfunction

  // Line fill symbols come back as not valid
  function automatic phy_lane_pkg::lane_bus_t loopback_of(input phy_lane_pkg::lane_bus_t row);
    phy_lane_pkg::lane_bus_t  res;
    phy_lane_pkg::lane_byte_t b;
    res = row;
    for (int i = 0; i < 4; i++) begin
      b = lane_byte(row, i);
      if (b == 8'hbc || b == 8'h7c) begin
        res.valid[i] = 1'b0;
      end
    end
    return res;
  endfunction

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
      abort_run("flag mismatch");
    end
  endtask

  // Valid field always compared, bytes only where byte_mask is set
  task automatic check_lanes(input phy_lane_pkg::lane_bus_t got,
                             input phy_lane_pkg::lane_bus_t want,
                             input phy_lane_pkg::lane_valid_t byte_mask,
                             input string what);
    logic bad;
    bad = (got.valid !== want.valid);
    for (int i = 0; i < 4; i++) begin
      if (byte_mask[i] && (lane_byte(got, i) !== lane_byte(want, i))) begin
        bad = 1'b1;
      end
    end
    if (bad) begin
      $display("FAIL %0t: %s is %h, expected %h (byte mask %b)",
               $time, what, got, want, byte_mask);
      abort_run("lane mismatch");
    end
  endtask

  task automatic build_table();
    phy_lane_pkg::lane_bus_t row;
    for (int i = 0; i < num_rows; i++) begin
      case (i % 12)
        4:       row = {8'h11, 8'h22, 8'h33, 8'h44, 4'b1111};
        5:       row = {8'ha5, 8'h5a, 8'hc3, 8'h3c, 4'b0001};
        6:       row = {8'h96, 8'h69, 8'h0f, 8'hf0, 4'b0100};
        7:       row = {8'hbc, 8'h7c, 8'h01, 8'hbc, 4'b1111};
        8:       row = {8'h7c, 8'hbc, 8'h7c, 8'h80, 4'b1011};
        9:       row = {8'h00, 8'hff, 8'h55, 8'haa, 4'b0000};
        default: begin
          row.lane0 = phy_lane_pkg::lane_byte_t'($urandom());
          row.lane1 = phy_lane_pkg::lane_byte_t'($urandom());
          row.lane2 = phy_lane_pkg::lane_byte_t'($urandom());
          row.lane3 = phy_lane_pkg::lane_byte_t'($urandom());
          row.valid = phy_lane_pkg::lane_valid_t'($urandom());
        end
      endcase
      stim[i]    = row;
      exp_out[i] = loopback_of(row);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (reset_cycles) @(negedge clk32f);
    check_flag(active, 1'b0, "active under reset");
    check_flag(out_strobe, 1'b0, "out_strobe under reset");
    check_flag(in_taken, 1'b0, "in_taken under reset");
    check_flag(|lanes_out.valid, 1'b0, "lanes_out valid under reset");
    check_flag(|lanes_recir.valid, 1'b0, "lanes_recir valid under reset");
    exp_q.delete();
    recir_pending = 1'b0;
    seen_active   = 1'b0;
    rel_cycle     = 0;
    loop_count    = 0;
    low_rows      = 0;
    reset         = 1'b0;
  endtask

  // One clock cycle of checks, then new stimulus on the falling edge
  task automatic step_cycle();
    phy_lane_pkg::lane_bus_t want;
    logic                    taken_exp;
    @(negedge clk32f);
    rel_cycle++;
    taken_exp = ((rel_cycle - 1) % frame_cycles) == 0;
    check_flag(in_taken, taken_exp, "in_taken");
    if (recir_pending) begin
      check_lanes(lanes_recir, recir_exp, recir_mask, "lanes_recir");
      recir_pending = 1'b0;
    end
    if (active) begin
      seen_active = 1'b1;
    end
    if (seen_active || rel_cycle > lock_limit) begin
      check_flag(active, 1'b1, "active");
    end
    if (out_strobe) begin
      if (exp_q.size() == 0) begin
        $display("Error: out_strobe at %0t with no frame waiting", $time);
        abort_run("unexpected out_strobe");
      end else begin
        want = exp_q.pop_front();
        check_lanes(lanes_out, want, want.valid, "lanes_out");
        loop_count++;
      end
    end
    if (in_taken && row_idx < row_limit) begin
      lanes_in   = stim[row_idx];
      recir_exp  = stim[row_idx];
      recir_mask = 4'b1111;
      // Link up keeps the frame on the line and out of recirculation
      if (active) begin
        recir_exp.valid = '0;
        recir_mask      = '0;
        exp_q.push_back(exp_out[row_idx]);
      end else begin
        low_rows++;
      end
      recir_pending = 1'b1;
      row_idx++;
    end
  endtask

  task automatic run_rows(input int limit);
    row_limit = limit;
    while (row_idx < row_limit || exp_q.size() != 0 || recir_pending) begin
      step_cycle();
    end
    check_flag(low_rows != 0, 1'b1, "rows sampled with link down");
    check_flag(loop_count != 0, 1'b1, "frames looped back");
  endtask

  initial begin
    #(run_cycles * clk_period);
    $display("Error: the run timed out after %0d clock cycles", run_cycles);
    abort_run("watchdog expired");
  end

  initial begin
    seed_val = $urandom(32'ha136_032b);
    reset    = 1'b1;
    lanes_in = '0;
    row_idx  = 0;
    build_table();
    apply_reset();
    run_rows(num_rows / 2);
    // Reset again halfway through the table
    apply_reset();
    run_rows(num_rows);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- source/phy.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY top, transmit and receive layers
// joined by a registered serial line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy #(
  parameter int bits_per_byte = 8
) (
  input  logic                    clk32f,
  input  logic                    reset,
  input  phy_lane_pkg::lane_bus_t lanes_in,
  output phy_lane_pkg::lane_bus_t lanes_out,
  output logic                    out_strobe,
  output phy_lane_pkg::lane_bus_t lanes_recir,
  output logic                    in_taken,
  output logic                    active
);

  logic serial_tx;
  logic serial_rx;

  // Receiver lock state doubles as the transmitter link_up
  phy_tx #(
    .bits_per_byte (bits_per_byte)
  ) i_phy_tx (
    .clk32f      (clk32f),
    .reset       (reset),
    .lanes_in    (lanes_in),
    .link_up     (active),
    .lanes_recir (lanes_recir),
    .in_taken    (in_taken),
    .serial_tx   (serial_tx)
  );

  // One flop of line delay between the layers
  always_ff @(posedge clk32f) begin
    serial_rx <= serial_tx;
  end

  phy_rx #(
    .bits_per_byte (bits_per_byte)
  ) i_phy_rx (
    .clk32f     (clk32f),
    .reset      (reset),
    .serial_rx  (serial_rx),
    .lanes_out  (lanes_out),
    .out_strobe (out_strobe),
    .active     (active)
  );

endmodule

//--- source/phy_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY receive layer, deserializer and
// 1:4 lane demux with output registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_rx #(
  parameter int bits_per_byte = 8
) (
  input  logic                    clk32f,
  input  logic                    reset,
  input  logic                    serial_rx,
  output phy_lane_pkg::lane_bus_t lanes_out,
  output logic                    out_strobe,
  output logic                    active
);

  phy_lane_pkg::lane_byte_t rx_byte;
  phy_lane_pkg::lane_idx_t  lane_slot;
  phy_lane_pkg::lane_bus_t  stage;
  phy_lane_pkg::lane_bus_t  stage_next;
  logic                     byte_valid;
  logic                     locked;
  logic                     byte_is_data;
  logic                     seen_slot0;
  logic                     frame_done;

  phy_deserializer #(
    .bits_per_byte (bits_per_byte)
  ) i_phy_deserializer (
    .clk32f     (clk32f),
    .reset      (reset),
    .serial_in  (serial_rx),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid),
    .lane_slot  (lane_slot),
    .locked     (locked)
  );

  assign active       = locked;
  // Line fill symbols never count as data
  assign byte_is_data = (rx_byte != phy_code_pkg::sym_com) &&
                        (rx_byte != phy_code_pkg::sym_idle);

  always_comb begin
    stage_next = stage;
    case (lane_slot)
      2'd0:    stage_next.lane0 = rx_byte;
      2'd1:    stage_next.lane1 = rx_byte;
      2'd2:    stage_next.lane2 = rx_byte;
      default: stage_next.lane3 = rx_byte;
    endcase
    stage_next.valid[lane_slot] = byte_is_data;
  end

  // Partial frame right after lock has no slot 0 and is dropped
  assign frame_done = byte_valid && (lane_slot == 2'd3) && seen_slot0;

  always_ff @(posedge clk32f) begin
    if (byte_valid) begin
      stage <= stage_next;
    end
  end

  always_ff @(posedge clk32f) begin
    if (reset) begin
      seen_slot0      <= 1'b0;
      out_strobe      <= 1'b0;
      lanes_out.valid <= '0;
    end else begin
      out_strobe <= frame_done;
      if (byte_valid && (lane_slot == '0)) begin
        seen_slot0 <= 1'b1;
      end
      if (frame_done) begin
        lanes_out <= stage_next;
      end
    end
  end

endmodule

//--- source/phy_deserializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY deserializer, COM search, byte
// alignment and frame lock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_deserializer #(
  parameter int bits_per_byte = 8
) (
  input  logic                     clk32f,
  input  logic                     reset,
  input  logic                     serial_in,
  output phy_lane_pkg::lane_byte_t rx_byte,
  output logic                     byte_valid,
  output phy_lane_pkg::lane_idx_t  lane_slot,
  output logic                     locked
);

  localparam int bit_w = $clog2(bits_per_byte);

  logic [bits_per_byte-1:0] shreg;
  logic [bit_w-1:0]         bit_cnt;
  phy_lane_pkg::lane_idx_t  slot_q;
  phy_code_pkg::rx_lock_t   state;
  logic                     is_com;
  logic                     is_idle;
  logic                     byte_tick;

  // Newest bit enters at the LSB
  always_ff @(posedge clk32f) begin
    shreg <= {shreg[bits_per_byte-2:0], serial_in};
  end

  assign is_com    = (shreg == phy_code_pkg::sym_com);
  assign is_idle   = (shreg == phy_code_pkg::sym_idle);
  // A full aligned byte sits in shreg when the phase counter is 0
  assign byte_tick = (state != phy_code_pkg::hunt) && (bit_cnt == '0);
  assign locked    = (state == phy_code_pkg::locked);

  always_ff @(posedge clk32f) begin
    if (reset) begin
      state   <= phy_code_pkg::hunt;
      bit_cnt <= '0;
      slot_q  <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        phy_code_pkg::hunt: begin
          // COM seen at any offset fixes the byte phase
          if (is_com) begin
            bit_cnt <= bit_w'(1);
            slot_q  <= 2'd1;
            state   <= phy_code_pkg::check_frame;
          end
        end
        phy_code_pkg::check_frame: begin
          if (byte_tick) begin
            slot_q <= slot_q + 2'd1;
            if (slot_q == '0) begin
              state <= is_com ? phy_code_pkg::locked : phy_code_pkg::hunt;
            end else if (!is_idle) begin
              state <= phy_code_pkg::hunt;
            end
          end
        end
        phy_code_pkg::locked: begin
          // Only reset leaves this state
          if (byte_tick) begin
            slot_q <= slot_q + 2'd1;
          end
        end
        default: state <= phy_code_pkg::hunt;
      endcase
    end
  end

  always_ff @(posedge clk32f) begin
    if (reset) begin
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= locked && byte_tick;
    end
  end

  always_ff @(posedge clk32f) begin
    if (locked && byte_tick) begin
      rx_byte   <= shreg;
      lane_slot <= slot_q;
    end
  end

endmodule

//--- source/phy_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY transmit layer, frame timing, lane
// mux and serializer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_tx #(
  parameter int bits_per_byte = 8
) (
  input  logic                    clk32f,
  input  logic                    reset,
  input  phy_lane_pkg::lane_bus_t lanes_in,
  input  logic                    link_up,
  output phy_lane_pkg::lane_bus_t lanes_recir,
  output logic                    in_taken,
  output logic                    serial_tx
);

  localparam int frame_len = 4 * bits_per_byte;
  localparam int cnt_w     = $clog2(frame_len);
  localparam int byte_w    = $clog2(bits_per_byte);

  logic [cnt_w-1:0]         count;
  logic                     run;
  logic                     frame_start;
  logic                     byte_start;
  phy_lane_pkg::lane_byte_t slot_byte;
  logic                     slot_load;

  // Frame counter holds at 0 until run is set
  always_ff @(posedge clk32f) begin
    if (reset) begin
      run   <= 1'b0;
      count <= '0;
    end else begin
      run <= 1'b1;
      if (run) begin
        count <= (count == cnt_w'(frame_len - 1)) ? '0 : count + 1'b1;
      end
    end
  end

  assign frame_start = run && (count == '0);
  assign byte_start  = run && (count[byte_w-1:0] == '0);
  assign in_taken    = frame_start;

  phy_tx_mux i_phy_tx_mux (
    .clk32f      (clk32f),
    .reset       (reset),
    .frame_start (frame_start),
    .byte_start  (byte_start),
    .link_up     (link_up),
    .lanes_in    (lanes_in),
    .lanes_recir (lanes_recir),
    .slot_byte   (slot_byte),
    .slot_load   (slot_load)
  );

  phy_serializer #(
    .bits_per_byte (bits_per_byte)
  ) i_phy_serializer (
    .clk32f     (clk32f),
    .reset      (reset),
    .slot_byte  (slot_byte),
    .slot_load  (slot_load),
    .serial_out (serial_tx)
  );

endmodule

//--- source/phy_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY serializer, byte to bit stream,
// most significant bit first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_serializer #(
  parameter int bits_per_byte = 8
) (
  input  logic                     clk32f,
  input  logic                     reset,
  input  phy_lane_pkg::lane_byte_t slot_byte,
  input  logic                     slot_load,
  output logic                     serial_out
);

  logic [bits_per_byte-1:0] shreg;

  // One load every bits_per_byte cycles from the mux,
  // shifting in between
  always_ff @(posedge clk32f) begin
    if (reset) begin
      // Line idles on COM until the first slot arrives
      shreg <= phy_code_pkg::sym_com;
    end else if (slot_load) begin
      shreg <= slot_byte;
    end else begin
      shreg <= {shreg[bits_per_byte-2:0], 1'b0};
    end
  end

  // MSB leads
  assign serial_out = shreg[bits_per_byte-1];

endmodule

//--- source/phy_tx_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY transmit mux, frame sampling,
// recirculation and 4:1 byte slot select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phy_tx_mux (
  input  logic                    clk32f,
  input  logic                    reset,
  input  logic                    frame_start,
  input  logic                    byte_start,
  input  logic                    link_up,
  input  phy_lane_pkg::lane_bus_t lanes_in,
  output phy_lane_pkg::lane_bus_t lanes_recir,
  output phy_lane_pkg::lane_byte_t slot_byte,
  output logic                    slot_load
);

  phy_lane_pkg::lane_bus_t  frame_q;
  phy_lane_pkg::lane_bus_t  cur_bus;
  phy_lane_pkg::lane_idx_t  slot_q;
  phy_lane_pkg::lane_idx_t  sel;
  phy_lane_pkg::lane_byte_t sel_byte;
  phy_lane_pkg::lane_byte_t fill_byte;
  logic                     recir_frame;
  logic                     cur_recir;

  // Slot 0 goes out in the sampling cycle, so bypass the frame register there
  assign cur_bus   = frame_start ? lanes_in : frame_q;
  assign cur_recir = frame_start ? ~link_up : recir_frame;
  assign sel       = frame_start ? '0 : slot_q;

  always_comb begin
    case (sel)
      2'd0:    sel_byte = cur_bus.lane0;
      2'd1:    sel_byte = cur_bus.lane1;
      2'd2:    sel_byte = cur_bus.lane2;
      default: sel_byte = cur_bus.lane3;
    endcase
    fill_byte = (sel == '0) ? phy_code_pkg::sym_com : phy_code_pkg::sym_idle;
  end

  always_ff @(posedge clk32f) begin
    if (reset) begin
      recir_frame       <= 1'b1;
      slot_q            <= '0;
      slot_load         <= 1'b0;
      lanes_recir.valid <= '0;
    end else begin
      slot_load <= byte_start;
      if (byte_start) begin
        slot_q <= sel + 2'd1;
      end
      if (frame_start) begin
        recir_frame <= ~link_up;
        // Link down sends the frame back, link up keeps only the bytes
        lanes_recir <= lanes_in;
        if (link_up) begin
          lanes_recir.valid <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk32f) begin
    if (frame_start) begin
      frame_q <= lanes_in;
    end
    if (byte_start) begin
      slot_byte <= (cur_recir || !cur_bus.valid[sel]) ? fill_byte : sel_byte;
    end
  end

endmodule

//--- source/phy_code_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY line code symbols and lock states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package phy_code_pkg;

  // Frame marker, always in slot 0 of an idle frame
  localparam phy_lane_pkg::lane_byte_t sym_com = 8'hbc;

  // Filler for slots 1 to 3 and for lanes with no data
  localparam phy_lane_pkg::lane_byte_t sym_idle = 8'h7c;

  // Receiver alignment FSM
  typedef enum logic [1:0] {
    hunt,
    check_frame,
    locked
  } rx_lock_t;

endpackage

//--- source/phy_lane_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY lane types for the parallel side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package phy_lane_pkg;

  // One byte of one lane
  typedef logic [7:0] lane_byte_t;

  // One valid flag per lane, bit n for lane n
  typedef logic [3:0] lane_valid_t;

  // Slot number of a byte within a frame
  typedef logic [1:0] lane_idx_t;

  // Four lanes plus their valid flags, 36 bits
  typedef struct packed {
    lane_byte_t  lane0;
    lane_byte_t  lane1;
    lane_byte_t  lane2;
    lane_byte_t  lane3;
    lane_valid_t valid;
  } lane_bus_t;

endpackage
